/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // address and data widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;
  localparam int unsigned HALF_W = 16;
  localparam int unsigned ROW_W  = 128;

  // 8 KB direct mapped, 128 lines of 64 bytes
  localparam int unsigned OFFSET_W = 6;
  localparam int unsigned INDEX_W  = 7;
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // offset split: row in line, halfword in row, byte bit
  localparam int unsigned ROW_SEL_W  = 2;
  localparam int unsigned HALF_SEL_W = 3;
  // word lane in a row, fed by the low beat count bits
  localparam int unsigned LANE_W     = 2;

  // refill burst, one 32-bit word per beat
  localparam int unsigned BEATS_PER_LINE = 16;
  // burst length field is beats minus one
  localparam logic [7:0]  REFILL_LEN     = 8'(BEATS_PER_LINE - 1);

  // uncached window, top nibble 0x1
  localparam logic [ADDR_W-1:0] UNCACHED_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] UNCACHED_MASK = 32'hF000_0000;

  // fetch controller states
  typedef enum logic [2:0] {
    CTRL_RESET    = 3'd0,
    CTRL_IDLE     = 3'd1,
    CTRL_LOOKUP   = 3'd2,
    CTRL_REFILL   = 3'd3,
    CTRL_UNCACHED = 3'd4
  } ctrl_state_e;

  // one data row, written per word lane, read per halfword
  typedef union packed {
    logic [ROW_W/WORD_W-1:0][WORD_W-1:0] words;
    logic [ROW_W/HALF_W-1:0][HALF_W-1:0] halves;
  } row_u;

endpackage

`default_nettype wire

/* icache_refill_if.sv */
`default_nettype none

interface icache_refill_if;
  import icache_pkg::*;

  // one write per cycle while wen is high, no handshake
  logic                         wen;
  // {line index, row select}
  logic [INDEX_W+ROW_SEL_W-1:0] row;
  // word lane inside the row
  logic [LANE_W-1:0]            lane;
  // refill beat as it came from memory
  logic [WORD_W-1:0]            wdata;

  // miss controller side
  modport ctrl (
    output wen, row, lane, wdata
  );

  // data store side
  modport store (
    input wen, row, lane, wdata
  );

endinterface

`default_nettype wire

/* icache_req_decode.sv */
`default_nettype none

module icache_req_decode (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              capture_i,
  input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
  output logic [icache_pkg::TAG_W-1:0]      tag_o,
  output logic [icache_pkg::INDEX_W-1:0]    index_o,
  output logic [icache_pkg::ROW_SEL_W-1:0]  row_sel_o,
  output logic [icache_pkg::HALF_SEL_W-1:0] half_sel_o,
  output logic [icache_pkg::ADDR_W-1:0]     line_addr_o,
  output logic [icache_pkg::ADDR_W-1:0]     req_addr_o,
  output logic                              uncached_o
);
  import icache_pkg::*;

  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_cur;

  // request address, held for the whole fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
    end else if (capture_i) begin
      addr_q <= fetch_addr_i;
    end
  end

  // incoming address on the capture cycle so the row read starts early
  assign addr_cur = capture_i ? fetch_addr_i : addr_q;

  // tag | index | row | halfword | byte
  assign tag_o      = addr_cur[ADDR_W-1 -: TAG_W];
  assign index_o    = addr_cur[OFFSET_W +: INDEX_W];
  assign row_sel_o  = addr_cur[OFFSET_W-1 -: ROW_SEL_W];
  assign half_sel_o = addr_cur[1 +: HALF_SEL_W];

  // burst start for a refill
  assign line_addr_o = {addr_cur[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign req_addr_o  = addr_cur;

  // fixed io window, never allocated
  assign uncached_o = (addr_cur & UNCACHED_MASK) == UNCACHED_BASE;

endmodule

`default_nettype wire

/* icache_tag_store.sv */
`default_nettype none

module icache_tag_store (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic [icache_pkg::TAG_W-1:0]   tag_i,
  input  logic                           tag_wen_i,
  output logic                           hit_o
);
  import icache_pkg::*;

  // one valid bit and one tag per line
  logic [(1 << INDEX_W)-1:0] valid_q;
  logic [TAG_W-1:0]          tags_q [1 << INDEX_W];

  // all lines invalid out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_wen_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag written with the last refill beat
  always_ff @(posedge clk) begin
    if (tag_wen_i) begin
      tags_q[index_i] <= tag_i;
    end
  end

  // combinational lookup on the held index and tag
  assign hit_o = valid_q[index_i] && (tags_q[index_i] == tag_i);

endmodule

`default_nettype wire

/* icache_data_store.sv */
`default_nettype none

module icache_data_store (
  input  logic                                                  clk,
  input  logic [icache_pkg::INDEX_W+icache_pkg::ROW_SEL_W-1:0] rd_row_i,
  icache_refill_if.store                                       refill,
  output icache_pkg::row_u                                     row_o
);
  import icache_pkg::*;

  // 128 lines x 4 rows of 128 bits
  row_u mem_q [1 << (INDEX_W + ROW_SEL_W)];

  // refill writes a single word lane
  // other lanes of the row keep their contents
  always_ff @(posedge clk) begin
    if (refill.wen) begin
      mem_q[refill.row].words[refill.lane] <= refill.wdata;
    end
  end

  // synchronous read, row valid the cycle after the address
  always_ff @(posedge clk) begin
    row_o <= mem_q[rd_row_i];
  end

endmodule

`default_nettype wire

/* icache_miss_ctrl.sv */
`default_nettype none

module icache_miss_ctrl (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           fetch_valid_i,
  input  logic                           hit_i,
  input  logic                           uncached_i,
  input  logic [icache_pkg::INDEX_W-1:0] index_i,
  input  logic [icache_pkg::ADDR_W-1:0]  line_addr_i,
  input  logic [icache_pkg::ADDR_W-1:0]  req_addr_i,
  input  logic                           mem_beat_i,
  input  logic [icache_pkg::WORD_W-1:0]  mem_rdata_i,
  output logic                           capture_o,
  output logic                           tag_wen_o,
  output logic [icache_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic                           mem_req_o,
  output logic [7:0]                     mem_len_o,
  output logic                           done_o,
  output logic [icache_pkg::WORD_W-1:0]  uncached_word_o,
  output logic                           use_uncached_o,
  icache_refill_if.ctrl                  refill
);
  import icache_pkg::*;

  ctrl_state_e                       state_q;
  logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_q;
  logic                              uc_done_q;
  logic                              refill_beat;
  logic                              last_beat;

  // beat count reaches the burst length
  assign last_beat   = beat_cnt_q == mem_len_o[$bits(beat_cnt_q)-1:0];
  assign refill_beat = (state_q == CTRL_REFILL) && mem_beat_i;

  // no capture in the done cycle, cpu still holds the old request
  assign capture_o = (state_q == CTRL_IDLE) && fetch_valid_i && !uc_done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= CTRL_RESET;
      mem_req_o  <= 1'b0;
      beat_cnt_q <= '0;
      uc_done_q  <= 1'b0;
    end else begin
      uc_done_q <= 1'b0;
      case (state_q)
        CTRL_RESET: begin
          state_q <= CTRL_IDLE;
        end
        CTRL_IDLE: begin
          if (capture_o) begin
            state_q <= CTRL_LOOKUP;
          end
        end
        CTRL_LOOKUP: begin
          beat_cnt_q <= '0;
          // io window bypasses the tag check
          if (uncached_i) begin
            state_q   <= CTRL_UNCACHED;
            mem_req_o <= 1'b1;
          end else if (hit_i) begin
            state_q <= CTRL_IDLE;
          end else begin
            state_q   <= CTRL_REFILL;
            mem_req_o <= 1'b1;
          end
        end
        CTRL_REFILL: begin
          if (mem_beat_i) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            // line complete, back to idle for a second lookup
            if (last_beat) begin
              mem_req_o <= 1'b0;
              state_q   <= CTRL_IDLE;
            end
          end
        end
        CTRL_UNCACHED: begin
          // single beat, answered next cycle
          if (mem_beat_i) begin
            mem_req_o <= 1'b0;
            uc_done_q <= 1'b1;
            state_q   <= CTRL_IDLE;
          end
        end
        default: begin
          state_q <= CTRL_IDLE;
        end
      endcase
    end
  end

  // burst setup, stable while mem_req_o is high
  always_ff @(posedge clk) begin
    if (state_q == CTRL_LOOKUP) begin
      if (uncached_i) begin
        mem_addr_o <= req_addr_i;
        mem_len_o  <= 8'd0;
      end else begin
        mem_addr_o <= line_addr_i;
        mem_len_o  <= REFILL_LEN;
      end
    end
  end

  // uncached beat kept for the done cycle
  always_ff @(posedge clk) begin
    if ((state_q == CTRL_UNCACHED) && mem_beat_i) begin
      uncached_word_o <= mem_rdata_i;
    end
  end

  // beat n goes to row n/4, lane n%4
  assign refill.wen   = refill_beat;
  assign refill.row   = {index_i, beat_cnt_q[LANE_W +: ROW_SEL_W]};
  assign refill.lane  = beat_cnt_q[LANE_W-1:0];
  assign refill.wdata = mem_rdata_i;

  // tag goes valid with the last beat
  assign tag_wen_o = refill_beat && last_beat;

  // hit in lookup or the registered uncached beat
  assign done_o         = ((state_q == CTRL_LOOKUP) && !uncached_i && hit_i) || uc_done_q;
  assign use_uncached_o = uc_done_q;

endmodule

`default_nettype wire

/* icache_inst_align.sv */
`default_nettype none

module icache_inst_align (
  input  icache_pkg::row_u                  row_i,
  input  logic [icache_pkg::HALF_SEL_W-1:0] half_sel_i,
  input  logic [icache_pkg::WORD_W-1:0]     uncached_word_i,
  input  logic                              use_uncached_i,
  output logic [icache_pkg::WORD_W-1:0]     inst_o
);
  import icache_pkg::*;

  logic [HALF_SEL_W-1:0] next_sel;
  logic [HALF_W-1:0]     cur_half;
  logic [HALF_W-1:0]     next_half;
  logic                  full_len;
  logic                  last_half;

  // wraps at the row end, ignored there
  assign next_sel  = half_sel_i + 1'b1;
  assign cur_half  = row_i.halves[half_sel_i];
  assign next_half = row_i.halves[next_sel];

  // rv quadrant 3 means a 32-bit instruction
  assign full_len  = cur_half[1:0] == 2'b11;
  // no upper half available in this row
  assign last_half = half_sel_i == {HALF_SEL_W{1'b1}};

  always_comb begin
    if (use_uncached_i) begin
      // io word returned as read
      inst_o = uncached_word_i;
    end else if (full_len && !last_half) begin
      inst_o = {next_half, cur_half};
    end else begin
      // compressed, or a split 32-bit one with zero upper half
      inst_o = {{(WORD_W - HALF_W){1'b0}}, cur_half};
    end
  end

endmodule

`default_nettype wire

/* icache_top.sv */
`default_nettype none

module icache_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                          fetch_valid_i,
  output logic [icache_pkg::WORD_W-1:0] inst_o,
  output logic                          inst_valid_o,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                          mem_req_o,
  output logic [7:0]                    mem_len_o,
  input  logic                          mem_beat_i,
  input  logic [icache_pkg::WORD_W-1:0] mem_rdata_i
);
  import icache_pkg::*;

  logic                  capture;
  logic [TAG_W-1:0]      tag;
  logic [INDEX_W-1:0]    index;
  logic [ROW_SEL_W-1:0]  row_sel;
  logic [HALF_SEL_W-1:0] half_sel;
  logic [ADDR_W-1:0]     line_addr;
  logic [ADDR_W-1:0]     req_addr;
  logic                  uncached;
  logic                  hit;
  logic                  tag_wen;
  logic [WORD_W-1:0]     uncached_word;
  logic                  use_uncached;
  row_u                  row;

  // refill writes, controller to data store
  icache_refill_if refill_if ();

  icache_req_decode icache_req_decode_inst (
    .clk          (clk),
    .rst          (rst),
    .capture_i    (capture),
    .fetch_addr_i (fetch_addr_i),
    .tag_o        (tag),
    .index_o      (index),
    .row_sel_o    (row_sel),
    .half_sel_o   (half_sel),
    .line_addr_o  (line_addr),
    .req_addr_o   (req_addr),
    .uncached_o   (uncached)
  );

  icache_tag_store icache_tag_store_inst (
    .clk       (clk),
    .rst       (rst),
    .index_i   (index),
    .tag_i     (tag),
    .tag_wen_i (tag_wen),
    .hit_o     (hit)
  );

  // read row follows the decoded index and row select
  icache_data_store icache_data_store_inst (
    .clk      (clk),
    .rd_row_i ({index, row_sel}),
    .refill   (refill_if.store),
    .row_o    (row)
  );

  icache_miss_ctrl icache_miss_ctrl_inst (
    .clk             (clk),
    .rst             (rst),
    .fetch_valid_i   (fetch_valid_i),
    .hit_i           (hit),
    .uncached_i      (uncached),
    .index_i         (index),
    .line_addr_i     (line_addr),
    .req_addr_i      (req_addr),
    .mem_beat_i      (mem_beat_i),
    .mem_rdata_i     (mem_rdata_i),
    .capture_o       (capture),
    .tag_wen_o       (tag_wen),
    .mem_addr_o      (mem_addr_o),
    .mem_req_o       (mem_req_o),
    .mem_len_o       (mem_len_o),
    .done_o          (inst_valid_o),
    .uncached_word_o (uncached_word),
    .use_uncached_o  (use_uncached),
    .refill          (refill_if.ctrl)
  );

  icache_inst_align icache_inst_align_inst (
    .row_i           (row),
    .half_sel_i      (half_sel),
    .uncached_word_i (uncached_word),
    .use_uncached_i  (use_uncached),
    .inst_o          (inst_o)
  );

endmodule

`default_nettype wire

/* icache_tb.sv */
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  // 64 KB model covering the cacheable and io windows
  localparam int unsigned MEM_WORDS = 16384;
  localparam int unsigned CYCLES_PER_LINE = 200;

  logic              clk;
  logic              rst;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_valid;
  logic [WORD_W-1:0] inst;
  logic              inst_valid;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_req;
  logic [7:0]        mem_len;
  logic              mem_beat = 1'b0;
  logic [WORD_W-1:0] mem_rdata = '0;

  logic [WORD_W-1:0] mem_model [MEM_WORDS];
  logic              req_seen;
  int unsigned       beats_sent;
  int unsigned       req_count;
  logic [ADDR_W-1:0] req_addr_seen;
  logic [7:0]        req_len_seen;

  // fetch list from the trace
  logic [ADDR_W-1:0] fetch_addr_q [$];
  logic [WORD_W-1:0] fetch_exp_q [$];
  int unsigned       trace_lines = 0;
  logic              trace_loaded = 1'b0;

  // expected valid bits and tags of the 128 lines
  logic [127:0]      ref_valid = '0;
  logic [18:0]       ref_tag [128];

  icache_top icache_top_inst (
    .clk          (clk),
    .rst          (rst),
    .fetch_addr_i (fetch_addr),
    .fetch_valid_i(fetch_valid),
    .inst_o       (inst),
    .inst_valid_o (inst_valid),
    .mem_addr_o   (mem_addr),
    .mem_req_o    (mem_req),
    .mem_len_o    (mem_len),
    .mem_beat_i   (mem_beat),
    .mem_rdata_i  (mem_rdata)
  );

  always #4 clk = ~clk;

  // bit 28 picks the io half and bits 14..2 the word
  function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
    return {addr[28], addr[14:2]};
  endfunction

  function automatic logic in_model(input logic [ADDR_W-1:0] addr);
    return (addr[31:29] == 3'b000) && (addr[27:15] == 13'd0);
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic load_trace();
    int                fd;
    string             line;
    byte               kind;
    int                fields;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    fd = $fopen("icache_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file icache_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      kind = line[0];
      // blank lines and comments
      if (line.len() < 2 || kind == "#") begin
        continue;
      end
      fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, data);
      if ((kind != "W" && kind != "F") || fields != 2) begin
        abort_run($sformatf("trace line could not be read: %s", line));
      end else if (!in_model(addr)) begin
        abort_run($sformatf("trace address %08h is outside the memory model", addr));
      end else if (kind == "W") begin
        mem_model[word_index(addr)] = data;
      end else begin
        fetch_addr_q.push_back(addr);
        fetch_exp_q.push_back(data);
      end
      trace_lines++;
    end
    $fclose(fd);
    trace_loaded = 1'b1;
  endtask

  // memory model answering bursts with random gaps between beats
  initial begin
    // fixed seed for the beat gaps
    void'($urandom(32'hdc84));
    forever begin
      @(posedge clk);
      if (rst) begin
        mem_beat   <= 1'b0;
        req_seen   <= 1'b0;
        beats_sent <= 0;
        req_count  <= 0;
      end else begin
        req_seen <= mem_req;
        mem_beat <= 1'b0;
        // note the burst setup on a rising request
        if (mem_req && !req_seen) begin
          req_count     <= req_count + 1;
          req_addr_seen <= mem_addr;
          req_len_seen  <= mem_len;
        end
        if (!mem_req) begin
          beats_sent <= 0;
        end else if (beats_sent <= mem_len && ($urandom % 3) != 0) begin
          mem_beat   <= 1'b1;
          mem_rdata  <= mem_model[word_index(mem_addr + 4 * beats_sent)];
          beats_sent <= beats_sent + 1;
        end else begin
          // junk on the data bus during gaps
          mem_rdata <= $urandom;
        end
      end
    end
  end

  task automatic run_fetch(input int n, input logic [ADDR_W-1:0] addr,
                           input logic [WORD_W-1:0] expected);
    string       name;
    logic        uncached;
    logic        miss;
    int unsigned reqs_before;
    name = $sformatf("fetch %0d at %08h", n, addr);
    // io window is the 0x1 top nibble
    uncached = addr[31:28] == 4'h1;
    miss = !ref_valid[addr[12:6]] || (ref_tag[addr[12:6]] != addr[31:13]);
    reqs_before = req_count;
    @(posedge clk);
    fetch_addr  <= addr;
    fetch_valid <= 1'b1;
    @(posedge clk);
    while (!inst_valid) begin
      @(posedge clk);
    end
    // drop the request once the pulse is seen
    fetch_valid <= 1'b0;
    check_value({name, " inst"}, expected, inst);
    if (uncached || miss) begin
      check_value({name, " requests"}, 1, req_count - reqs_before);
      // io read is one beat at the exact address
      if (uncached) begin
        check_value({name, " mem_addr"}, addr, req_addr_seen);
        check_value({name, " mem_len"}, 0, req_len_seen);
      end else begin
        check_value({name, " mem_addr"}, {addr[31:6], 6'd0}, req_addr_seen);
        check_value({name, " mem_len"}, 15, req_len_seen);
        ref_valid[addr[12:6]] = 1'b1;
        ref_tag[addr[12:6]]   = addr[31:13];
      end
    end else begin
      check_value({name, " requests"}, 0, req_count - reqs_before);
    end
  endtask

  // limit grows with the trace length
  initial begin
    wait (trace_loaded);
    repeat (trace_lines * CYCLES_PER_LINE) @(posedge clk);
    abort_run($sformatf("timeout: the fetches did not finish within %0d cycles",
                        trace_lines * CYCLES_PER_LINE));
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    load_trace();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < fetch_addr_q.size(); i++) begin
      run_fetch(i, fetch_addr_q[i], fetch_exp_q[i]);
    end
    @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* icache_trace.txt */
# W <addr> <data>: preload one 32-bit memory word (hex)
# F <addr> <inst>: fetch at addr, expect inst on inst_o (hex)
W 00000100 05134501
W 00000104 80820010
W 00000108 00C500B3
W 0000010C 12344185
W 00000128 ABCD0003
W 00002100 00A30293
W 10000040 CAFE0001
F 00000100 00004501
F 00000102 00100513
F 00000104 00000010
F 00000106 00008082
F 00000108 00C500B3
F 0000010A 000000C5
F 0000010C 00004185
F 0000010E 00001234
F 00000128 ABCD0003
F 00002100 00A30293
F 00000100 00004501
F 00002100 00A30293
F 10000040 CAFE0001
F 10000040 CAFE0001

/* icache.f */
icache_pkg.sv
icache_refill_if.sv
icache_req_decode.sv
icache_tag_store.sv
icache_data_store.sv
icache_miss_ctrl.sv
icache_inst_align.sv
icache_top.sv
icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_refill_if.sv
  - icache_req_decode.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_miss_ctrl.sv
  - icache_inst_align.sv
  - icache_top.sv
  - target: test
    files:
      - icache_tb.sv
